// ==== rtl/lanzones_macros.svh ====
`ifndef LANZONES_MACROS_SVH
`define LANZONES_MACROS_SVH

`define LZ_XLEN     32
`define LZ_REG_BITS 5

// major opcodes
`define LZ_OP_IMM    7'b0010011
`define LZ_OP_REG    7'b0110011
`define LZ_OP_LOAD   7'b0000011
`define LZ_OP_STORE  7'b0100011
`define LZ_OP_BRANCH 7'b1100011
`define LZ_OP_HALT   7'h7F

`define LZ_F3_ADD  3'b000
`define LZ_F3_XOR  3'b100
`define LZ_F3_OR   3'b110
`define LZ_F3_AND  3'b111
`define LZ_F3_WORD 3'b010 // LW and SW
`define LZ_F3_BEQ  3'b000
`define LZ_F3_BNE  3'b001
`define LZ_F7_BASE 7'b0000000
`define LZ_F7_ALT  7'b0100000 // SUB

`endif

// ==== rtl/lanzonesPkg.sv ====
`default_nettype none

`include "lanzones_macros.svh"

package lanzonesPkg;

   typedef logic [`LZ_XLEN-1:0]     word_t;
   typedef logic [`LZ_REG_BITS-1:0] regAddr_t;
   typedef logic [6:0]              opcode_t;

   // immediate forms share opAdd..opXor, see useImm
   typedef enum logic [3:0] {
      opNone,
      opAdd,
      opSub,
      opAnd,
      opOr,
      opXor,
      opLoad,
      opStore,
      opBeq,
      opBne,
      opHalt,
      opInvalid
   } coreOp_e;

   typedef enum logic [1:0] {stIdle, stFetch, stExecute, stMem} ctrlState_e;

endpackage

`default_nettype wire

// ==== rtl/decodeIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface decodeIf;
   import lanzonesPkg::*;

   coreOp_e  op;
   logic     useImm; // second operand from imm
   regAddr_t rd;
   regAddr_t rs1;
   regAddr_t rs2;
   word_t    imm;

   modport source (
      output op, useImm, rd, rs1, rs2, imm
   );

   modport sink (
      input op, useImm, rd, rs1, rs2, imm
   );
endinterface

`default_nettype wire

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lanzones_macros.svh"

module instrDecoder (
   input  logic               clk,
   input  logic               rstn,
   input  logic               instrLoad,
   input  lanzonesPkg::word_t memRData,
   decodeIf.source            dec
);
   import lanzonesPkg::*;

   word_t      instr;
   opcode_t    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      immI;
   word_t      immS;
   word_t      immB;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         instr <= '0;
      end else if (instrLoad) begin
         instr <= memRData;
      end
   end

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign immI = {{(`LZ_XLEN-12){instr[31]}}, instr[31:20]};
   assign immS = {{(`LZ_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{(`LZ_XLEN-12){1'b0}}, instr[31:25], instr[11:7]}; // absolute word address

   // register fields are taken as-is, consumers ignore the unused ones
   assign dec.rd  = instr[11:7];
   assign dec.rs1 = instr[19:15];
   assign dec.rs2 = instr[24:20];

   always_comb begin
      dec.op     = opNone;
      dec.useImm = 1'b0;
      dec.imm    = immI;
      case (opcode)
         `LZ_OP_IMM: begin
            dec.useImm = 1'b1;
            case (funct3)
               `LZ_F3_ADD: dec.op = opAdd;
               `LZ_F3_XOR: dec.op = opXor;
               `LZ_F3_OR:  dec.op = opOr;
               `LZ_F3_AND: dec.op = opAnd;
               default:    dec.op = opInvalid;
            endcase
         end
         `LZ_OP_REG: begin
            if (funct7 == `LZ_F7_BASE) begin
               case (funct3)
                  `LZ_F3_ADD: dec.op = opAdd;
                  `LZ_F3_XOR: dec.op = opXor;
                  `LZ_F3_OR:  dec.op = opOr;
                  `LZ_F3_AND: dec.op = opAnd;
                  default:    dec.op = opInvalid;
               endcase
            end else if (funct7 == `LZ_F7_ALT && funct3 == `LZ_F3_ADD) begin
               dec.op = opSub;
            end else begin
               dec.op = opInvalid;
            end
         end
         `LZ_OP_LOAD: begin
            dec.useImm = 1'b1;
            dec.op     = (funct3 == `LZ_F3_WORD) ? opLoad : opInvalid;
         end
         `LZ_OP_STORE: begin
            dec.useImm = 1'b1;
            dec.imm    = immS;
            dec.op     = (funct3 == `LZ_F3_WORD) ? opStore : opInvalid;
         end
         `LZ_OP_BRANCH: begin
            dec.imm = immB;
            case (funct3)
               `LZ_F3_BEQ: dec.op = opBeq;
               `LZ_F3_BNE: dec.op = opBne;
               default:    dec.op = opInvalid;
            endcase
         end
         `LZ_OP_HALT: dec.op = opHalt;
         default:     dec.op = opInvalid;
      endcase
   end
endmodule

`default_nettype wire

// ==== rtl/aluUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
   decodeIf.sink              dec,
   input  lanzonesPkg::word_t rs1Data,
   input  lanzonesPkg::word_t rs2Data,
   output lanzonesPkg::word_t result,
   output logic               equal
);
   import lanzonesPkg::*;

   word_t opB;

   assign opB = dec.useImm ? dec.imm : rs2Data;

   always_comb begin
      case (dec.op)
         opAdd,
         opLoad,
         opStore: result = rs1Data + opB; // also the data address
         opSub:   result = rs1Data - opB;
         opAnd:   result = rs1Data & opB;
         opOr:    result = rs1Data | opB;
         opXor:   result = rs1Data ^ opB;
         default: result = '0;
      endcase
   end

   // branch compare always on registers
   assign equal = (rs1Data == rs2Data);
endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lanzones_macros.svh"

module regFile (
   input  logic               clk,
   input  logic               rstn,
   decodeIf.sink              dec,
   input  logic               wrEn,
   input  logic               wrFromMem,
   input  lanzonesPkg::word_t aluResult,
   input  lanzonesPkg::word_t memRData,
   output lanzonesPkg::word_t rs1Data,
   output lanzonesPkg::word_t rs2Data
);
   import lanzonesPkg::*;

   localparam int numRegs = 1 << `LZ_REG_BITS;

   word_t regs [numRegs];
   word_t wrData;

   assign wrData = wrFromMem ? memRData : aluResult;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && dec.rd != '0) begin // x0 stays zero
         regs[dec.rd] <= wrData;
      end
   end

   assign rs1Data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
   assign rs2Data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];
endmodule

`default_nettype wire

// ==== rtl/pcCounter.sv ====
`timescale 1ns/10ps
`default_nettype none

module pcCounter (
   input  logic               clk,
   input  logic               rstn,
   input  logic               restart,
   input  logic               advance,
   decodeIf.sink              dec,
   input  logic               equal,
   output lanzonesPkg::word_t pc
);
   import lanzonesPkg::*;

   logic taken;

   assign taken = (dec.op == opBeq && equal) || (dec.op == opBne && !equal);

   // word addressed, one step per instruction
   always_ff @(posedge clk) begin
      if (!rstn || restart) begin
         pc <= '0;
      end else if (advance) begin
         if (taken) begin
            pc <= dec.imm;
         end else begin
            pc <= pc + 1'b1;
         end
      end
   end
endmodule

`default_nettype wire

// ==== rtl/coreControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreControl (
   input  logic               clk,
   input  logic               rstn,
   input  logic               loadEn,
   input  logic               memValid,
   decodeIf.sink              dec,
   input  lanzonesPkg::word_t pc,
   input  lanzonesPkg::word_t aluResult,
   input  lanzonesPkg::word_t rs2Data,
   output logic               memReady,
   output lanzonesPkg::word_t memAddr,
   output logic               memWEn,
   output lanzonesPkg::word_t memWData,
   output logic               halt,
   output logic               instrLoad,
   output logic               restart,
   output logic               advance,
   output logic               wrEn,
   output logic               wrFromMem
);
   import lanzonesPkg::*;

   ctrlState_e state;
   logic       xfer;
   logic       isAluOp;
   logic       isMemOp;
   logic       fetchSetup;

   assign xfer       = memReady && memValid;
   assign isAluOp    = dec.op inside {opAdd, opSub, opAnd, opOr, opXor};
   assign isMemOp    = (dec.op == opLoad) || (dec.op == opStore);
   assign fetchSetup = (state == stFetch) && !memReady; // first fetch cycle, pc settled

   assign restart   = (state == stIdle) && loadEn;
   assign instrLoad = (state == stFetch) && xfer;
   assign advance   = (state == stExecute);
   assign wrFromMem = (state == stMem);
   assign wrEn      = ((state == stExecute) && isAluOp) ||
                      ((state == stMem) && xfer && dec.op == opLoad);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state    <= stIdle;
         halt     <= 1'b1;
         memReady <= 1'b0;
         memWEn   <= 1'b0;
      end else begin
         case (state)
            stIdle: begin
               if (loadEn) begin
                  halt     <= 1'b0;
                  memReady <= 1'b1; // fetch from 0 right away
                  memWEn   <= 1'b0;
                  state    <= stFetch;
               end
            end
            stFetch: begin
               if (xfer) begin
                  memReady <= 1'b0;
                  state    <= stExecute;
               end else if (fetchSetup) begin
                  memReady <= 1'b1;
               end
            end
            stExecute: begin
               if (dec.op == opHalt || dec.op == opInvalid) begin
                  halt  <= 1'b1;
                  state <= stIdle;
               end else if (isMemOp) begin
                  memReady <= 1'b1;
                  memWEn   <= (dec.op == opStore);
                  state    <= stMem;
               end else begin
                  state <= stFetch;
               end
            end
            stMem: begin
               if (xfer) begin
                  memReady <= 1'b0;
                  memWEn   <= 1'b0;
                  state    <= stFetch;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // address and store data, held while memReady is up
   always_ff @(posedge clk) begin
      if (restart) begin
         memAddr <= '0;
      end else if (fetchSetup) begin
         memAddr <= pc;
      end else if (state == stExecute && isMemOp) begin
         memAddr  <= aluResult;
         memWData <= rs2Data;
      end
   end
endmodule

`default_nettype wire

// ==== rtl/lanzonesTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module lanzonesTop (
   input  logic               clk,
   input  logic               rstn,
   input  logic               memValid,
   input  lanzonesPkg::word_t memRData,
   output logic               memReady,
   output lanzonesPkg::word_t memAddr,
   output logic               memWEn,
   output lanzonesPkg::word_t memWData,
   output logic               halt,
   input  logic               loadEn
);
   import lanzonesPkg::*;

   word_t pc;
   word_t aluResult;
   word_t rs1Data;
   word_t rs2Data;
   logic  equal;
   logic  instrLoad;
   logic  restart;
   logic  advance;
   logic  wrEn;
   logic  wrFromMem;

   decodeIf dec_i ();

   instrDecoder decoder_i (
      .clk       (clk),
      .rstn      (rstn),
      .instrLoad (instrLoad),
      .memRData  (memRData),
      .dec       (dec_i.source)
   );

   aluUnit alu_i (
      .dec     (dec_i.sink),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .result  (aluResult),
      .equal   (equal)
   );

   regFile regs_i (
      .clk       (clk),
      .rstn      (rstn),
      .dec       (dec_i.sink),
      .wrEn      (wrEn),
      .wrFromMem (wrFromMem),
      .aluResult (aluResult),
      .memRData  (memRData),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data)
   );

   pcCounter pc_i (
      .clk     (clk),
      .rstn    (rstn),
      .restart (restart),
      .advance (advance),
      .dec     (dec_i.sink),
      .equal   (equal),
      .pc      (pc)
   );

   coreControl ctrl_i (
      .clk       (clk),
      .rstn      (rstn),
      .loadEn    (loadEn),
      .memValid  (memValid),
      .dec       (dec_i.sink),
      .pc        (pc),
      .aluResult (aluResult),
      .rs2Data   (rs2Data),
      .memReady  (memReady),
      .memAddr   (memAddr),
      .memWEn    (memWEn),
      .memWData  (memWData),
      .halt      (halt),
      .instrLoad (instrLoad),
      .restart   (restart),
      .advance   (advance),
      .wrEn      (wrEn),
      .wrFromMem (wrFromMem)
   );
endmodule

`default_nettype wire

// ==== tb/lanzonesTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lanzonesTb;
   localparam int memDepth = 1024;
   localparam logic [31:0] lfsrTaps = 32'h8020_0003;
   localparam logic [6:0] opImm = 7'h13;
   localparam logic [6:0] opReg = 7'h33;
   localparam logic [2:0] f3Add = 3'b000;
   localparam logic [2:0] f3Xor = 3'b100;
   localparam logic [2:0] f3Or = 3'b110;
   localparam logic [2:0] f3And = 3'b111;
   localparam logic [31:0] haltInstr = 32'h0000_007F;

   logic        clk;
   logic        rstn;
   logic        memValid;
   logic [31:0] memRData;
   logic        memReady;
   logic [31:0] memAddr;
   logic        memWEn;
   logic [31:0] memWData;
   logic        halt;
   logic        loadEn;

   logic [31:0] mem [memDepth];
   logic [31:0] lfsr = 32'd71900;
   logic [31:0] storeAddr [$];
   logic [31:0] storeData [$];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   int          progLen;
   logic        pending;
   int          delayLeft;
   logic [31:0] xAddr;
   logic [31:0] xData;
   logic        xWrite;

   lanzonesTop dut_i (
      .clk      (clk),
      .rstn     (rstn),
      .memValid (memValid),
      .memRData (memRData),
      .memReady (memReady),
      .memAddr  (memAddr),
      .memWEn   (memWEn),
      .memWData (memWData),
      .halt     (halt),
      .loadEn   (loadEn)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abortRun(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic compareValue(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // galois lfsr, one step per bit taken
   function automatic int randomBits(input int n);
      int v;
      int i;
      v = 0;
      for (i = 0; i < n; i++) begin
         v = (v << 1) | int'(lfsr[0]);
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsrTaps) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opReg};
   endfunction

   function automatic logic [31:0] iType(input logic [6:0] opc, input logic [2:0] f3,
                                         input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
   endfunction

   function automatic logic [31:0] loadWord(input int rd, input int rs1, input int off);
      return iType(7'h03, 3'b010, rd, rs1, off);
   endfunction

   function automatic logic [31:0] storeWord(input int rs2, input int rs1, input int off);
      return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'h23};
   endfunction

   // target is an absolute word address in the S-type immediate slots
   function automatic logic [31:0] branchTo(input logic [2:0] f3, input int rs1,
                                            input int rs2, input int target);
      return {target[11:5], rs2[4:0], rs1[4:0], f3, target[4:0], 7'h63};
   endfunction

   task automatic emit(input logic [31:0] w);
      mem[progLen] = w;
      progLen++;
   endtask

   task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic compareStores();
      compareValue("store count", storeAddr.size(), expAddr.size());
      foreach (expAddr[i]) begin
         compareValue($sformatf("store %0d address", i), storeAddr[i], expAddr[i]);
         compareValue($sformatf("store %0d data", i), storeData[i], expData[i]);
      end
      expAddr.delete();
      expData.delete();
   endtask

   task automatic checkIdle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         compareValue("halt", halt, 1'b1);
         compareValue("memReady", memReady, 1'b0);
         compareValue("memWEn", memWEn, 1'b0);
      end
   endtask

   task automatic awaitHalt(input int limit);
      int n;
      n = 0;
      while (!halt) begin
         @(negedge clk);
         n++;
         if (n > limit) abortRun("core did not halt within the cycle limit");
      end
   endtask

   task automatic startAndRun();
      storeAddr.delete();
      storeData.delete();
      loadEn = 1'b1;
      @(negedge clk);
      loadEn = 1'b0;
      awaitHalt(3000);
   endtask

   // memory model, answers after 0 to 3 cycles
   initial begin
      memValid = 1'b0;
      memRData = '0;
      pending = 1'b0;
      delayLeft = 0;
      for (int i = 0; i < memDepth; i++) begin
         mem[i] = 32'hC0DE_0000 ^ i;
      end
      forever begin
         @(negedge clk);
         if (!rstn) begin
            memValid = 1'b0;
            pending = 1'b0;
         end else if (memValid) begin
            // handshake done on the last rising edge
            if (xWrite) begin
               mem[xAddr[9:0]] = xData;
               storeAddr.push_back(xAddr);
               storeData.push_back(xData);
            end
            memValid = 1'b0;
            pending = 1'b0;
         end else if (memReady) begin
            if (!pending) begin
               pending = 1'b1;
               delayLeft = randomBits(2);
            end
            if (memAddr >= memDepth) abortRun("memory access outside the model");
            if (delayLeft == 0) begin
               xAddr = memAddr;
               xData = memWData;
               xWrite = memWEn;
               memRData = mem[memAddr[9:0]];
               memValid = 1'b1;
            end else begin
               delayLeft--;
            end
         end else if (pending) begin
            abortRun("memReady dropped before the handshake");
         end
      end
   end

   task automatic resetIdle();
      rstn = 1'b0;
      checkIdle(10);
      rstn = 1'b1;
      checkIdle(20); // no loadEn yet
   endtask

   task automatic opsProgram();
      logic [31:0] a;
      logic [31:0] b;
      int k;
      a = 32'd1234;
      b = -32'sd300;
      progLen = 0;
      emit(iType(opImm, f3Add, 1, 0, 1234));
      emit(iType(opImm, f3Add, 2, 0, -300));
      emit(rType(7'h00, f3Add, 3, 1, 2));
      emit(rType(7'h20, f3Add, 4, 1, 2)); // sub
      emit(rType(7'h00, f3And, 5, 1, 2));
      emit(rType(7'h00, f3Or, 6, 1, 2));
      emit(rType(7'h00, f3Xor, 7, 1, 2));
      emit(iType(opImm, f3And, 8, 2, -16));
      emit(iType(opImm, f3Or, 9, 2, 291));
      emit(iType(opImm, f3Xor, 10, 1, -1));
      emit(rType(7'h00, f3Add, 0, 1, 1)); // lost in x0
      for (k = 3; k <= 10; k++) begin
         emit(storeWord(k, 0, 512 + k));
      end
      emit(storeWord(0, 0, 600));
      emit(haltInstr);
      expectStore(515, a + b);
      expectStore(516, a - b);
      expectStore(517, a & b);
      expectStore(518, a | b);
      expectStore(519, a ^ b);
      expectStore(520, b & 32'hFFFF_FFF0);
      expectStore(521, b | 32'h0000_0123);
      expectStore(522, a ^ 32'hFFFF_FFFF);
      expectStore(600, 32'h0);
      startAndRun();
      compareStores();
   endtask

   task automatic memoryProgram();
      logic [31:0] sum;
      mem[700] = 32'h89AB_CDEF;
      mem[701] = 32'h7654_3210;
      mem[710] = 32'h0000_1111;
      sum = 32'h89AB_CDEF + 32'h7654_3210 + 32'h0000_1111;
      progLen = 0;
      emit(iType(opImm, f3Add, 1, 0, 705));
      emit(loadWord(2, 1, -5));
      emit(loadWord(3, 1, -4));
      emit(loadWord(4, 1, 5));
      emit(rType(7'h00, f3Add, 5, 2, 3));
      emit(rType(7'h00, f3Add, 5, 5, 4));
      emit(storeWord(5, 1, 3));
      emit(storeWord(2, 1, -1));
      emit(iType(opImm, f3Add, 6, 0, 960));
      emit(storeWord(5, 6, -200));
      emit(storeWord(4, 6, 17));
      emit(loadWord(7, 1, 3)); // read back the first store
      emit(storeWord(7, 6, 0));
      emit(haltInstr);
      expectStore(705 + 3, sum);
      expectStore(705 - 1, 32'h89AB_CDEF);
      expectStore(960 - 200, sum);
      expectStore(960 + 17, 32'h0000_1111);
      expectStore(960, sum);
      startAndRun();
      compareStores();
   endtask

   task automatic branchProgram();
      progLen = 0;
      emit(iType(opImm, f3Add, 1, 0, 5));
      emit(iType(opImm, f3Add, 2, 0, 5));
      emit(iType(opImm, f3Add, 3, 0, 7));
      emit(branchTo(3'b000, 1, 2, 6)); // beq taken
      emit(storeWord(3, 0, 800));
      emit(storeWord(3, 0, 799));
      emit(storeWord(3, 0, 801)); // 6
      emit(branchTo(3'b000, 1, 3, 10)); // beq not taken
      emit(storeWord(3, 0, 802));
      emit(branchTo(3'b001, 1, 3, 12)); // bne taken
      emit(storeWord(3, 0, 803)); // 10
      emit(storeWord(3, 0, 804));
      emit(branchTo(3'b001, 1, 2, 15)); // 12, bne not taken
      emit(storeWord(3, 0, 805));
      emit(haltInstr);
      emit(storeWord(3, 0, 806)); // 15
      emit(haltInstr);
      expectStore(801, 32'd7);
      expectStore(802, 32'd7);
      expectStore(805, 32'd7);
      startAndRun();
      compareStores();
   endtask

   task automatic haltRestart();
      int n;
      progLen = 0;
      emit(iType(opImm, f3Add, 1, 0, 9));
      emit(iType(opImm, f3Add, 2, 0, 9));
      emit(haltInstr);
      emit(storeWord(1, 0, 850));
      startAndRun();
      compareValue("memAddr", memAddr, 32'd2); // last fetch was the 7F at word 2
      compareStores();
      checkIdle(20);
      progLen = 0;
      emit(iType(opImm, f3Add, 1, 0, 3));
      emit(branchTo(3'b010, 1, 1, 0)); // no such branch
      emit(storeWord(1, 0, 851));
      emit(haltInstr);
      startAndRun();
      compareValue("memAddr", memAddr, 32'd1); // stopped at the bad branch
      compareStores();
      checkIdle(20);
      loadEn = 1'b1;
      @(negedge clk);
      loadEn = 1'b0;
      n = 0;
      while (!memReady) begin
         @(negedge clk);
         n++;
         if (n > 10) abortRun("memReady did not rise after loadEn");
      end
      compareValue("memAddr", memAddr, 32'h0); // fetch restarts at 0
      awaitHalt(3000);
      compareValue("memAddr", memAddr, 32'd1); // word 1 again only with pc cleared
      compareStores();
   endtask

   initial begin
      rstn = 1'b0;
      loadEn = 1'b0;
      resetIdle();
      opsProgram();
      memoryProgram();
      branchProgram();
      haltRestart();
      $display("Simulation completed successfully");
      $finish;
   end
endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/lanzonesPkg.sv
rtl/decodeIf.sv
rtl/instrDecoder.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/pcCounter.sv
rtl/coreControl.sv
rtl/lanzonesTop.sv
tb/lanzonesTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if ! verilator --binary --timing -Wno-fatal -f sim.f --top-module lanzonesTb \
      -o lanzonesSim; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/lanzonesSim; then
   echo "simulation run returned a failing status"
   exit 1
fi

exit 0
